//--- hw_pkg.sv
package hw_pkg;

   // ---------------------------------------
   // bus and register widths
   // ---------------------------------------
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   // default led / dip width, top level may override
   localparam int VLED_W_DEF = 16;

   // ---------------------------------------
   // register map
   // ---------------------------------------
   localparam logic [ADDR_W-1:0] HELLO_ADDR   = 32'h0000_0500;
   localparam logic [ADDR_W-1:0] VLED_ADDR    = 32'h0000_0504;
   // returned for any address outside the map
   localparam logic [DATA_W-1:0] UNIMPL_VALUE = 32'hDEAD_BEEF;
   localparam logic [1:0]        RESP_OKAY    = 2'b00;

   // ---------------------------------------
   // axi-lite channel bundles
   // ---------------------------------------
   // write request, host to slave
   typedef struct packed {
      logic              awvalid;
      logic [ADDR_W-1:0] awaddr;
      logic              wvalid;
      logic [DATA_W-1:0] wdata;
      logic              bready;
   } axil_wr_req_t;

   // write response, slave to host
   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      logic [1:0] bresp;
   } axil_wr_rsp_t;

   // read request, host to slave
   typedef struct packed {
      logic              arvalid;
      logic [ADDR_W-1:0] araddr;
      logic              rready;
   } axil_rd_req_t;

   // read response, slave to host
   typedef struct packed {
      logic              arready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic [1:0]        rresp;
   } axil_rd_rsp_t;

   // internal register write strobe, one cycle wide
   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } reg_wr_t;

endpackage

//--- hw_axil_write.sv
`timescale 1ns/1ns

module hw_axil_write
(
   input  logic                 clk,
   input  logic                 rst_main_n,
   input  hw_pkg::axil_wr_req_t i_req,
   output hw_pkg::axil_wr_rsp_t o_rsp,
   output hw_pkg::reg_wr_t      o_reg_wr
);

   // idle waits for an address, active runs until the response is taken
   typedef enum logic
   {
      WR_IDLE,
      WR_ACTIVE
   } wr_state_t;

   wr_state_t                 state_q;
   logic [hw_pkg::ADDR_W-1:0] awaddr_q;
   // data taken, bvalid goes up on the next edge
   logic                      rsp_pend_q;
   logic                      bvalid_q;

   logic                      wready;
   logic                      aw_hs;
   logic                      w_hs;
   logic                      b_hs;

   // ---------------------------------------
   // handshakes
   // ---------------------------------------
   // data only once the address is in and no response is outstanding
   assign wready = (state_q == WR_ACTIVE) && i_req.wvalid && !rsp_pend_q && !bvalid_q;
   assign aw_hs  = i_req.awvalid && (state_q == WR_IDLE);
   assign w_hs   = wready && i_req.wvalid;
   assign b_hs   = bvalid_q && i_req.bready;

   // ---------------------------------------
   // tracker state
   // ---------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_main_n)
      begin
         state_q    <= WR_IDLE;
         rsp_pend_q <= 1'b0;
         bvalid_q   <= 1'b0;
      end
      else
      begin
         case (state_q)
            WR_IDLE:
            begin
               if (aw_hs)
                  state_q <= WR_ACTIVE;
            end
            default:
            begin
               // response accepted ends the write
               if (b_hs)
                  state_q <= WR_IDLE;
            end
         endcase
         // single cycle, wready is blocked while it is set
         rsp_pend_q <= w_hs;
         if (rsp_pend_q)
            bvalid_q <= 1'b1;
         else if (b_hs)
            bvalid_q <= 1'b0;
      end
   end

   // address latch
   always_ff @(posedge clk)
   begin
      if (aw_hs)
         awaddr_q <= i_req.awaddr;
   end

   // ---------------------------------------
   // outputs
   // ---------------------------------------
   assign o_rsp.awready = (state_q == WR_IDLE);
   assign o_rsp.wready  = wready;
   assign o_rsp.bvalid  = bvalid_q;
   // no error responses
   assign o_rsp.bresp   = hw_pkg::RESP_OKAY;

   // full word write, strobe lasts the data handshake cycle
   assign o_reg_wr.en   = w_hs;
   assign o_reg_wr.addr = awaddr_q;
   assign o_reg_wr.data = i_req.wdata;

endmodule

//--- hw_axil_read.sv
`timescale 1ns/1ns

module hw_axil_read
(
   input  logic                      clk,
   input  logic                      rst_main_n,
   input  hw_pkg::axil_rd_req_t      i_req,
   output hw_pkg::axil_rd_rsp_t      o_rsp,
   output logic [hw_pkg::ADDR_W-1:0] o_rd_addr,
   input  logic [hw_pkg::DATA_W-1:0] i_rd_data
);

   // address taken, decode settles during this cycle
   logic                      rd_pend_q;
   logic [hw_pkg::ADDR_W-1:0] araddr_q;
   logic                      rvalid_q;
   logic [hw_pkg::DATA_W-1:0] rdata_q;

   logic                      arready;
   logic                      ar_hs;
   logic                      r_hs;

   // ---------------------------------------
   // handshakes
   // ---------------------------------------
   // one read in flight at a time
   assign arready = !rd_pend_q && !rvalid_q;
   assign ar_hs   = i_req.arvalid && arready;
   assign r_hs    = rvalid_q && i_req.rready;

   // ---------------------------------------
   // read tracking
   // ---------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_main_n)
      begin
         rd_pend_q <= 1'b0;
         rvalid_q  <= 1'b0;
         rdata_q   <= '0;
      end
      else
      begin
         rd_pend_q <= ar_hs;
         if (rd_pend_q)
         begin
            // capture decoded word, held until the host takes it
            rvalid_q <= 1'b1;
            rdata_q  <= i_rd_data;
         end
         else if (r_hs)
         begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // address latch feeding the register decode
   always_ff @(posedge clk)
   begin
      if (ar_hs)
         araddr_q <= i_req.araddr;
   end

   // ---------------------------------------
   // outputs
   // ---------------------------------------
   assign o_rd_addr     = araddr_q;
   assign o_rsp.arready = arready;
   assign o_rsp.rvalid  = rvalid_q;
   assign o_rsp.rdata   = rdata_q;
   assign o_rsp.rresp   = hw_pkg::RESP_OKAY;

endmodule

//--- hw_regs.sv
`timescale 1ns/1ns

module hw_regs
#(
   parameter int P_VLED_W = 16
)
(
   input  logic                      clk,
   input  logic                      rst_main_n,
   input  hw_pkg::reg_wr_t           i_reg_wr,
   input  logic [hw_pkg::ADDR_W-1:0] i_rd_addr,
   output logic [hw_pkg::DATA_W-1:0] o_rd_data,
   output logic [P_VLED_W-1:0]       o_hello_low
);

   logic [hw_pkg::DATA_W-1:0] hello_q;
   // led shadow as seen by register reads
   logic [P_VLED_W-1:0]       vled_rd_q;
   logic [hw_pkg::DATA_W-1:0] hello_swapped;

   // ---------------------------------------
   // greeting register
   // ---------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_main_n)
      begin
         hello_q   <= '0;
         vled_rd_q <= '0;
      end
      else
      begin
         // writes elsewhere in the map are dropped
         if (i_reg_wr.en && (i_reg_wr.addr == hw_pkg::HELLO_ADDR))
            hello_q <= i_reg_wr.data;
         vled_rd_q <= hello_q[P_VLED_W-1:0];
      end
   end

   // byte order reversed on readback
   assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

   // ---------------------------------------
   // read decode
   // ---------------------------------------
   always_comb
   begin
      if (i_rd_addr == hw_pkg::HELLO_ADDR)
         o_rd_data = hello_swapped;
      else if (i_rd_addr == hw_pkg::VLED_ADDR)
         o_rd_data = {{(hw_pkg::DATA_W - P_VLED_W){1'b0}}, vled_rd_q};
      else
         o_rd_data = hw_pkg::UNIMPL_VALUE;
   end

   // low bits drive the led block
   assign o_hello_low = hello_q[P_VLED_W-1:0];

endmodule

//--- hw_vled.sv
`timescale 1ns/1ns

module hw_vled
#(
   parameter int P_VLED_W = 16
)
(
   input  logic                clk,
   input  logic                rst_main_n,
   input  logic [P_VLED_W-1:0] i_hello_low,
   input  logic [P_VLED_W-1:0] i_vdip,
   output logic [P_VLED_W-1:0] o_vled
);

   // dip switches come from another clock domain
   logic [P_VLED_W-1:0] vdip_q1;
   logic [P_VLED_W-1:0] vdip_q2;
   logic [P_VLED_W-1:0] vled_q;
   logic [P_VLED_W-1:0] vled_out_q;

   // ---------------------------------------
   // dip sync and led shadow
   // ---------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_main_n)
      begin
         vdip_q1    <= '0;
         vdip_q2    <= '0;
         vled_q     <= '0;
         vled_out_q <= '0;
      end
      else
      begin
         // two-flop synchronizer
         vdip_q1    <= i_vdip;
         vdip_q2    <= vdip_q1;
         // shadow follows the greeting low bits
         vled_q     <= i_hello_low;
         // switches mask the shadow
         vled_out_q <= vled_q & vdip_q2;
      end
   end

   assign o_vled = vled_out_q;

endmodule

//--- hw_top.sv
`timescale 1ns/1ns

module hw_top
#(
   parameter int P_VLED_W = hw_pkg::VLED_W_DEF
)
(
   input  logic                 clk,
   input  logic                 rst_main_n,
   // write channels
   input  hw_pkg::axil_wr_req_t i_wr_req,
   output hw_pkg::axil_wr_rsp_t o_wr_rsp,
   // read channels
   input  hw_pkg::axil_rd_req_t i_rd_req,
   output hw_pkg::axil_rd_rsp_t o_rd_rsp,
   // virtual switches and leds
   input  logic [P_VLED_W-1:0]  i_vdip,
   output logic [P_VLED_W-1:0]  o_vled
);

   // ---------------------------------------
   // internal wiring
   // ---------------------------------------
   // register write strobe from the write port
   hw_pkg::reg_wr_t           reg_wr;
   // read address out, decoded word back
   logic [hw_pkg::ADDR_W-1:0] rd_addr;
   logic [hw_pkg::DATA_W-1:0] rd_data;
   // greeting low bits toward the led block
   logic [P_VLED_W-1:0]       hello_low;

   // ---------------------------------------
   // bus front end
   // ---------------------------------------
   hw_axil_write i_hw_axil_write
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .i_req      (i_wr_req),
      .o_rsp      (o_wr_rsp),
      .o_reg_wr   (reg_wr)
   );

   hw_axil_read i_hw_axil_read
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .i_req      (i_rd_req),
      .o_rsp      (o_rd_rsp),
      .o_rd_addr  (rd_addr),
      .i_rd_data  (rd_data)
   );

   // ---------------------------------------
   // register file and led path
   // ---------------------------------------
   hw_regs
   #(
      .P_VLED_W (P_VLED_W)
   )
   i_hw_regs
   (
      .clk         (clk),
      .rst_main_n  (rst_main_n),
      .i_reg_wr    (reg_wr),
      .i_rd_addr   (rd_addr),
      .o_rd_data   (rd_data),
      .o_hello_low (hello_low)
   );

   hw_vled
   #(
      .P_VLED_W (P_VLED_W)
   )
   i_hw_vled
   (
      .clk         (clk),
      .rst_main_n  (rst_main_n),
      .i_hello_low (hello_low),
      .i_vdip      (i_vdip),
      .o_vled      (o_vled)
   );

endmodule

//--- tb_hw_top.sv
`timescale 1ns/1ns

module tb_hw_top;

   localparam int          CLK_PERIOD = 20;
   localparam logic [31:0] SEED       = 32'h4a6d_6516;
   localparam int          VLED_W     = hw_pkg::VLED_W_DEF;
   localparam int          N_HELLO    = 20;
   localparam int          N_UNIMPL   = 4;
   localparam int          N_LED      = 8;
   // one write and two reads per register round, one write per led step at most
   localparam int          N_TXN      = 3 * N_HELLO + 3 * N_UNIMPL + N_LED;

   // read address with its data word
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
   } rd_rec_t;

   logic                 clk = 1'b0;
   logic                 rst_main_n;
   hw_pkg::axil_wr_req_t wr_req;
   hw_pkg::axil_wr_rsp_t wr_rsp;
   hw_pkg::axil_rd_req_t rd_req;
   hw_pkg::axil_rd_rsp_t rd_rsp;
   logic [VLED_W-1:0]    vdip;
   logic [VLED_W-1:0]    vled;

   // last word written to the greeting register
   logic [31:0]          hello_model;
   int                   n_checks = 0;
   int                   n_errors = 0;
   // expected and observed reads, paired in order
   rd_rec_t              exp_q[$];
   rd_rec_t              act_q[$];
   rd_rec_t              exp_rec;
   rd_rec_t              act_rec;

   always #(CLK_PERIOD / 2) clk = ~clk;

   hw_top i_hw_top
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .i_wr_req   (wr_req),
      .o_wr_rsp   (wr_rsp),
      .i_rd_req   (rd_req),
      .o_rd_rsp   (rd_rsp),
      .i_vdip     (vdip),
      .o_vled     (vled)
   );

   // ---------------------------------------
   // reference model
   // ---------------------------------------
   function automatic logic [31:0] expected_read(input logic [31:0] addr,
                                                 input logic [31:0] hello);
      logic [31:0] word;
      word = hw_pkg::UNIMPL_VALUE;
      // byte b of the result is byte 3-b of the stored word
      if (addr == hw_pkg::HELLO_ADDR)
      begin
         for (int b = 0; b < 4; b++)
            word[8*b +: 8] = hello[8*(3-b) +: 8];
      end
      else if (addr == hw_pkg::VLED_ADDR)
         word = {{(32 - VLED_W){1'b0}}, hello[VLED_W-1:0]};
      return word;
   endfunction

   // switches mask the greeting low bits
   function automatic logic [VLED_W-1:0] expected_vled(input logic [31:0] hello,
                                                       input logic [VLED_W-1:0] dip);
      return hello[VLED_W-1:0] & dip;
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      n_checks++;
      if (actual !== expected)
      begin
         n_errors++;
         $display("ERROR @ %0t: %s, got 0x%08h expected 0x%08h", $time, what, actual,
                  expected);
      end
   endtask

   // compares read words once both sides are in
   always @(posedge clk)
   begin
      if (exp_q.size() > 0 && act_q.size() > 0)
      begin
         exp_rec = exp_q.pop_front();
         act_rec = act_q.pop_front();
         check_value(act_rec.data, exp_rec.data,
                     $sformatf("read data at 0x%08h", exp_rec.addr));
      end
   end

   // ---------------------------------------
   // host tasks
   // ---------------------------------------
   // entered and left 2 ns after a rising edge
   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                             input int hold);
      // address and data offered together
      wr_req.awvalid = 1'b1;
      wr_req.awaddr  = addr;
      wr_req.wvalid  = 1'b1;
      wr_req.wdata   = data;
      wr_req.bready  = 1'b0;
      @(negedge clk);
      while (!wr_rsp.awready)
         @(negedge clk);
      @(posedge clk);
      #2;
      wr_req.awvalid = 1'b0;
      // data accepted one cycle after the address
      @(negedge clk);
      check_value(wr_rsp.wready, 1'b1, "wready after address handshake");
      while (!wr_rsp.wready)
         @(negedge clk);
      @(posedge clk);
      #2;
      wr_req.wvalid = 1'b0;
      @(negedge clk);
      check_value(wr_rsp.bvalid, 1'b0, "bvalid before response edge");
      @(negedge clk);
      check_value(wr_rsp.bvalid, 1'b1, "bvalid one cycle after data handshake");
      check_value(wr_rsp.bresp, hw_pkg::RESP_OKAY, "bresp");
      // bready low, response and address channel stall
      repeat (hold)
      begin
         @(negedge clk);
         check_value(wr_rsp.bvalid, 1'b1, "bvalid held under back-pressure");
         check_value(wr_rsp.awready, 1'b0, "awready blocked by pending response");
      end
      @(posedge clk);
      #2;
      wr_req.bready = 1'b1;
      @(posedge clk);
      #2;
      wr_req.bready = 1'b0;
      @(negedge clk);
      check_value(wr_rsp.bvalid, 1'b0, "bvalid after response handshake");
      @(posedge clk);
      #2;
   endtask

   // queues the modelled word, then reads and queues the observed word
   task automatic read_check(input logic [31:0] addr, input int hold);
      rd_rec_t rec;
      rec.addr = addr;
      rec.data = expected_read(addr, hello_model);
      exp_q.push_back(rec);
      rd_req.arvalid = 1'b1;
      rd_req.araddr  = addr;
      rd_req.rready  = 1'b0;
      @(negedge clk);
      while (!rd_rsp.arready)
         @(negedge clk);
      @(posedge clk);
      #2;
      rd_req.arvalid = 1'b0;
      @(negedge clk);
      check_value(rd_rsp.rvalid, 1'b0, "rvalid before capture edge");
      @(negedge clk);
      check_value(rd_rsp.rvalid, 1'b1, "rvalid one cycle after address handshake");
      check_value(rd_rsp.rresp, hw_pkg::RESP_OKAY, "rresp");
      rec.data = rd_rsp.rdata;
      act_q.push_back(rec);
      // rready low, data must hold
      repeat (hold)
      begin
         @(negedge clk);
         check_value(rd_rsp.rvalid, 1'b1, "rvalid held under back-pressure");
         check_value(rd_rsp.rdata, rec.data, "rdata stable under back-pressure");
         check_value(rd_rsp.arready, 1'b0, "arready blocked by held response");
      end
      @(posedge clk);
      #2;
      rd_req.rready = 1'b1;
      @(posedge clk);
      #2;
      rd_req.rready = 1'b0;
      @(negedge clk);
      check_value(rd_rsp.rvalid, 1'b0, "rvalid after response handshake");
      @(posedge clk);
      #2;
   endtask

   // ---------------------------------------
   // stimulus
   // ---------------------------------------
   initial
   begin
      logic [31:0] data;
      logic [31:0] addr;
      // seed the generator once
      data        = $urandom(SEED);
      wr_req      = '0;
      rd_req      = '0;
      vdip        = '0;
      hello_model = '0;
      rst_main_n  = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      rst_main_n = 1'b1;

      // idle state after reset
      @(negedge clk);
      check_value(wr_rsp.bvalid, 1'b0, "bvalid after reset");
      check_value(rd_rsp.rvalid, 1'b0, "rvalid after reset");
      check_value(wr_rsp.awready, 1'b1, "awready after reset");
      check_value(rd_rsp.arready, 1'b1, "arready after reset");
      check_value(vled, '0, "o_vled after reset");
      @(posedge clk);
      #2;

      // greeting writes with swapped and shadow readback
      for (int i = 0; i < N_HELLO; i++)
      begin
         data = $urandom;
         axil_write(hw_pkg::HELLO_ADDR, data, 1 + ($urandom % 8));
         hello_model = data;
         read_check(hw_pkg::HELLO_ADDR, 1 + ($urandom % 8));
         read_check(hw_pkg::VLED_ADDR, 1 + ($urandom % 8));
      end

      // addresses outside the map, bit 16 keeps them off the registers
      for (int i = 0; i < N_UNIMPL; i++)
      begin
         addr = ($urandom | 32'h0001_0000) & 32'hFFFF_FFFC;
         axil_write(addr, $urandom, 0);
         read_check(hw_pkg::HELLO_ADDR, 0);
         read_check(addr, 0);
      end

      // led output against random switches
      for (int i = 0; i < N_LED; i++)
      begin
         if (i % 2 == 0)
         begin
            data = $urandom;
            axil_write(hw_pkg::HELLO_ADDR, data, 0);
            hello_model = data;
         end
         data = $urandom;
         vdip = data[VLED_W-1:0];
         repeat (5) @(posedge clk);
         @(negedge clk);
         check_value(vled, expected_vled(hello_model, vdip), "o_vled after settling");
         @(posedge clk);
         #2;
      end

      // let the compare process drain
      repeat (2) @(posedge clk);
      if (exp_q.size() != 0 || act_q.size() != 0)
      begin
         n_errors++;
         $display("read results left unpaired, %0d expected and %0d observed",
                  exp_q.size(), act_q.size());
      end
      $display("%0d checks run, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // watchdog sized on the transaction count
   initial
   begin
      repeat (200 * N_TXN + 100) @(posedge clk);
      $display("timeout, the run did not finish within %0d cycles", 200 * N_TXN + 100);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- project.f
hw_pkg.sv
hw_axil_write.sv
hw_axil_read.sv
hw_regs.sv
hw_vled.sv
hw_top.sv
tb_hw_top.sv
